/* all.f */
+incdir+include
src/cpu_pkg.sv
src/mem_agu.sv
src/data_ram.sv
src/mem_load_align.sv
src/mem_stage_top.sv
test/tb_mem_stage.sv

/* include/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory stage build options
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// 1 keeps the LWL/LWR merge path, 0 makes both ops write back zero
`define CPU_LWLR_ENABLED 1

`define CACHED_WORDS   256  // depth of the cached region RAM
`define UNCACHED_WORDS 64   // depth of the uncached region RAM

// physical address bit that steers an access to the uncached RAM
`define UNCACHED_BIT 20

`endif

/* run.sh */
#!/bin/sh
# build and run the memory stage testbench from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f all.f --top-module tb_mem_stage -o tb_mem_stage
output=$(./obj_dir/tb_mem_stage)
echo "$output"
if echo "$output" | grep -q "all tests passed"; then
	exit 0
fi
exit 1

/* src/cpu_pkg.sv */
package cpu_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// shared types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [31:0] uint32_t;

	// codes are fixed so that stimulus files can give them in hex
	typedef enum logic [3:0] {
		OP_ALU = 4'h0,
		OP_LB  = 4'h1,
		OP_LH  = 4'h2,
		OP_LW  = 4'h3,
		OP_LBU = 4'h4,
		OP_LHU = 4'h5,
		OP_LWL = 4'h6,
		OP_LWR = 4'h7,
		OP_SB  = 4'h8,
		OP_SH  = 4'h9,
		OP_SW  = 4'ha
	} oper_t;

	// LWL and LWR count as loads, they read memory and merge with rt
	function automatic logic is_load(input oper_t op);
		unique case (op)
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWL, OP_LWR: is_load = 1'b1;
			default: is_load = 1'b0;
		endcase
	endfunction

	function automatic logic is_store(input oper_t op);
		unique case (op)
			OP_SB, OP_SH, OP_SW: is_store = 1'b1;
			default: is_store = 1'b0;
		endcase
	endfunction

endpackage

/* src/data_ram.sv */
`include "cpu_params.svh"

module data_ram import cpu_pkg::*; #(
	parameter int WORDS = `CACHED_WORDS
) (
	input  logic       clk,
	input  uint32_t    addr,
	input  logic [3:0] byteenable,
	input  logic       we,
	input  uint32_t    wrdata,
	output uint32_t    rddata
);

localparam int AW = $clog2(WORDS);

logic [AW-1:0] index;
uint32_t       mem [WORDS] = '{default: '0};

// byte address in, the low two bits only pick lanes
assign index = addr[AW+1:2];

always_ff @(posedge clk) begin
	if (we) begin
		for (int lane = 0; lane < 4; lane++) begin
			if (byteenable[lane]) begin
				mem[index][8*lane +: 8] <= wrdata[8*lane +: 8];
			end
		end
	end
	rddata <= mem[index]; // read-before-write, a write in this cycle shows up next time
end

endmodule

/* src/mem_agu.sv */
`include "cpu_params.svh"

module mem_agu import cpu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       in_valid,
	input  oper_t      op,
	input  uint32_t    base,
	input  uint32_t    offset,
	input  uint32_t    store_val,
	input  uint32_t    reg2,
	input  uint32_t    alu_result,
	input  logic [4:0] rd,
	output logic       s1_valid,
	output oper_t      s1_op,
	output uint32_t    paddr,
	output logic [3:0] byteenable,
	output logic       uncached,
	output uint32_t    wrdata,
	output logic       mem_read,
	output logic       mem_write,
	output uint32_t    s1_result,
	output logic [4:0] s1_rd
);

uint32_t    addr_sum;
logic [1:0] addr_offset;
logic [1:0] lwl_shift;
logic [3:0] be_next;
uint32_t    wrdata_next;

assign addr_sum    = base + offset;
assign addr_offset = addr_sum[1:0];
assign lwl_shift   = 2'd3 - addr_offset;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lane decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_comb begin
	be_next     = 4'b0000;
	wrdata_next = store_val << {addr_offset, 3'b000}; // store data moves to its byte lane
	unique case (op)
		OP_LB, OP_LBU, OP_SB: be_next = 4'b0001 << addr_offset;
		OP_LH, OP_LHU, OP_SH: be_next = 4'b0011 << addr_offset;
		OP_LW, OP_SW:         be_next = 4'b1111;
		OP_LWL: begin
			be_next     = 4'b1111 << lwl_shift; // upper lanes, 3 down to 3 - offset
			wrdata_next = reg2;
		end
		OP_LWR: begin
			// memory bytes offset..3 land in the low lanes of rt
			be_next     = 4'b1111 >> addr_offset;
			wrdata_next = reg2;
		end
		default: be_next = 4'b0000; // ALU ops touch no lane
	endcase
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stage 1 register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_ff @(posedge clk) begin
	if (rst) begin
		s1_valid  <= 1'b0;
		mem_read  <= 1'b0;
		mem_write <= 1'b0;
	end else begin
		s1_valid  <= in_valid;
		mem_read  <= in_valid & is_load(op);  // strobes only fire with a live instruction
		mem_write <= in_valid & is_store(op);
	end
end

always_ff @(posedge clk) begin
	s1_op      <= op;
	paddr      <= addr_sum;
	byteenable <= be_next;
	uncached   <= addr_sum[`UNCACHED_BIT];
	wrdata     <= wrdata_next;
	s1_result  <= alu_result;
	s1_rd      <= rd;
end

endmodule

/* src/mem_load_align.sv */
`include "cpu_params.svh"

module mem_load_align import cpu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       valid,
	input  oper_t      op,
	input  uint32_t    paddr,
	input  logic [3:0] byteenable,
	input  logic       uncached,
	input  uint32_t    wrdata,
	input  uint32_t    exec_result,
	input  logic [4:0] rd,
	input  uint32_t    cached_rddata,
	input  uint32_t    uncached_rddata,
	output logic       wb_valid,
	output logic [4:0] wb_rd,
	output uint32_t    wb_data
);

uint32_t    data_rd;
logic [1:0] addr_offset;
logic [1:0] lwl_shift;
uint32_t    aligned_data_rd;
uint32_t    unaligned_data_rd;
uint32_t    lane_mask;
uint32_t    unaligned_word;
uint32_t    signed_ext_byte;
uint32_t    signed_ext_half;
uint32_t    zero_ext_byte;
uint32_t    zero_ext_half;
uint32_t    result_next;

assign data_rd     = uncached ? uncached_rddata : cached_rddata;
assign addr_offset = paddr[1:0];
assign lwl_shift   = 2'd3 - addr_offset;

assign aligned_data_rd = data_rd >> {addr_offset, 3'b000};
assign signed_ext_byte = {{24{aligned_data_rd[7]}}, aligned_data_rd[7:0]};
assign signed_ext_half = {{16{aligned_data_rd[15]}}, aligned_data_rd[15:0]};
assign zero_ext_byte   = {24'b0, aligned_data_rd[7:0]};
assign zero_ext_half   = {16'b0, aligned_data_rd[15:0]};

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LWL / LWR merge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

assign lane_mask = {{8{byteenable[3]}}, {8{byteenable[2]}},
	{8{byteenable[1]}}, {8{byteenable[0]}}};

assign unaligned_data_rd = (op == OP_LWL) ? data_rd << {lwl_shift, 3'b000}
	: data_rd >> {addr_offset, 3'b000};

generate
	if (`CPU_LWLR_ENABLED) begin : g_lwlr
		// wrdata carries the old rt here, memory lanes overwrite the enabled bytes
		assign unaligned_word = (wrdata & ~lane_mask) | (unaligned_data_rd & lane_mask);
	end else begin : g_no_lwlr
		assign unaligned_word = '0;
	end
endgenerate

always_comb begin
	result_next = exec_result; // ALU ops and stores pass through
	if (is_load(op)) begin
		unique case (op)
			OP_LB:          result_next = signed_ext_byte;
			OP_LH:          result_next = signed_ext_half;
			OP_LBU:         result_next = zero_ext_byte;
			OP_LHU:         result_next = zero_ext_half;
			OP_LWL, OP_LWR: result_next = unaligned_word;
			default:        result_next = aligned_data_rd;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (rst) wb_valid <= 1'b0;
	else     wb_valid <= valid;
end

always_ff @(posedge clk) begin
	wb_rd   <= rd;
	wb_data <= result_next;
end

endmodule

/* src/mem_stage_top.sv */
`include "cpu_params.svh"

module mem_stage_top import cpu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       in_valid,
	input  oper_t      op,
	input  uint32_t    base,
	input  uint32_t    offset,
	input  uint32_t    store_val,
	input  uint32_t    alu_result,
	input  uint32_t    reg2,
	input  logic [4:0] rd,
	output logic       wb_valid,
	output logic [4:0] wb_rd,
	output uint32_t    wb_data
);

logic       s1_valid, s2_valid;
oper_t      s1_op, s2_op;
uint32_t    paddr, s2_paddr;
logic [3:0] byteenable, s2_byteenable;
logic       uncached, s2_uncached;
uint32_t    wrdata, s2_wrdata;
logic       mem_read, mem_write;
uint32_t    s1_result, s2_result;
logic [4:0] s1_rd, s2_rd;
uint32_t    cached_rddata, uncached_rddata;

mem_agu agu_i (
	.clk, .rst, .in_valid, .op, .base, .offset, .store_val, .reg2, .alu_result, .rd,
	.s1_valid, .s1_op, .paddr, .byteenable, .uncached, .wrdata,
	.mem_read, .mem_write, .s1_result, .s1_rd
);

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RAM regions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

data_ram #(.WORDS(`CACHED_WORDS)) cached_ram_i (
	.clk, .addr(paddr), .byteenable, .we(mem_write & ~uncached), .wrdata,
	.rddata(cached_rddata)
);

data_ram #(.WORDS(`UNCACHED_WORDS)) uncached_ram_i (
	.clk, .addr(paddr), .byteenable, .we(mem_write & uncached), .wrdata,
	.rddata(uncached_rddata)
);

// stage 2 keeps pace with the registered RAM read
always_ff @(posedge clk) begin
	if (rst) s2_valid <= 1'b0;
	else     s2_valid <= s1_valid;
end

always_ff @(posedge clk) begin
	s2_op         <= s1_op;
	s2_paddr      <= paddr;
	s2_byteenable <= byteenable;
	s2_uncached   <= uncached & mem_read; // region pick only matters for the read mux
	s2_wrdata     <= wrdata;
	s2_result     <= s1_result;
	s2_rd         <= s1_rd;
end

mem_load_align load_align_i (
	.clk, .rst, .valid(s2_valid), .op(s2_op), .paddr(s2_paddr),
	.byteenable(s2_byteenable), .uncached(s2_uncached), .wrdata(s2_wrdata),
	.exec_result(s2_result), .rd(s2_rd), .cached_rddata, .uncached_rddata,
	.wb_valid, .wb_rd, .wb_data
);

endmodule

/* test/mem_stimulus.txt */
# op base offset store_val reg2 alu_result rd expected_wb_data
# all hex, op codes as in oper_t, lines starting with # are skipped
0 00000000 00000000 00000000 00000000 12345678 01 12345678
0 00000000 00000000 00000000 00000000 deadbeef 1f deadbeef
0 00000000 00000000 00000000 00000000 00000000 00 00000000
0 00000000 00000000 00000000 00000000 a5a5a5a5 0a a5a5a5a5
a 00000100 00000040 cafef00d 00000000 00000140 03 00000140
3 00000100 00000040 00000000 00000000 00000000 04 cafef00d
a 00100100 00000040 0badc0de 00000000 00100140 05 00100140
3 00100100 00000040 00000000 00000000 00000000 06 0badc0de
3 00000140 00000000 00000000 00000000 00000000 07 cafef00d
a 00000200 00000000 11223344 00000000 00000200 08 00000200
8 00000204 fffffffd 000000ab 00000000 00000201 09 00000201
8 00000200 00000003 000000cd 00000000 00000203 0a 00000203
9 00000200 00000002 0000beef 00000000 00000202 0b 00000202
8 000001fc 00000004 00000077 00000000 00000200 0c 00000200
3 00000200 00000000 00000000 00000000 00000000 0d beefab77
9 00000200 00000000 ffff1234 00000000 00000200 0e 00000200
3 00000200 00000000 00000000 00000000 00000000 0f beef1234
8 00100000 00000203 0000005a 00000000 00100203 10 00100203
3 00100000 00000200 00000000 00000000 00000000 11 5a000000
a 00000300 00000000 7bf68ac5 00000000 00000300 12 00000300
1 00000300 00000000 00000000 00000000 00000000 13 ffffffc5
1 00000300 00000001 00000000 00000000 00000000 14 ffffff8a
1 00000300 00000002 00000000 00000000 00000000 15 fffffff6
1 00000300 00000003 00000000 00000000 00000000 16 0000007b
4 00000300 00000000 00000000 00000000 00000000 17 000000c5
4 00000300 00000001 00000000 00000000 00000000 18 0000008a
4 00000300 00000002 00000000 00000000 00000000 19 000000f6
4 00000300 00000003 00000000 00000000 00000000 1a 0000007b
2 00000300 00000000 00000000 00000000 00000000 1b ffff8ac5
2 00000300 00000002 00000000 00000000 00000000 1c 00007bf6
5 00000300 00000000 00000000 00000000 00000000 1d 00008ac5
5 00000300 00000002 00000000 00000000 00000000 1e 00007bf6
6 00000300 00000000 00000000 11223344 00000000 01 c5223344
6 00000300 00000001 00000000 11223344 00000000 02 8ac53344
6 00000300 00000002 00000000 11223344 00000000 03 f68ac544
6 00000300 00000003 00000000 11223344 00000000 04 7bf68ac5
7 00000300 00000000 00000000 11223344 00000000 05 7bf68ac5
7 00000300 00000001 00000000 11223344 00000000 06 117bf68a
7 00000300 00000002 00000000 11223344 00000000 07 11227bf6
7 00000300 00000003 00000000 11223344 00000000 08 1122337b
0 00000000 00000000 00000000 00000000 0f0f0f0f 1f 0f0f0f0f

/* test/tb_mem_stage.sv */
module tb_mem_stage import cpu_pkg::*; ();

timeunit 1ns;
timeprecision 1ps;

logic       clk = 1'b0;
logic       rst;
logic       in_valid;
oper_t      op;
uint32_t    base;
uint32_t    offset;
uint32_t    store_val;
uint32_t    alu_result;
uint32_t    reg2;
logic [4:0] rd;
logic       wb_valid;
logic [4:0] wb_rd;
uint32_t    wb_data;

logic [2:0] sent_hist; // in_valid seen at the last three edges
logic [4:0] exp_rd_q[$];
uint32_t    exp_data_q[$];
int         check_count = 0;
int         error_count = 0;
int         run_error_count = 0;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DUT and clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

mem_stage_top dut_i (
	.clk, .rst, .in_valid, .op, .base, .offset, .store_val, .alu_result, .reg2, .rd,
	.wb_valid, .wb_rd, .wb_data
);

always #4 clk = ~clk;

// write-back trails in_valid by exactly three edges
always @(posedge clk) begin
	if (rst) sent_hist <= 3'b000;
	else     sent_hist <= {sent_hist[1:0], in_valid};
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result checking
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic check_value(input string name, input logic [31:0] actual,
	input logic [31:0] expected);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
	end
endtask

// outputs settle after the rising edge, so look at them on the falling one
always @(negedge clk) begin
	logic [4:0] exp_rd;
	uint32_t    exp_data;
	check_value("wb_valid", 32'(wb_valid), 32'(sent_hist[2]));
	if (wb_valid === 1'b1 && !rst) begin
		if (exp_data_q.size() == 0) begin
			error_count++;
			$display("a write-back result came out with no instruction waiting for it");
		end else begin
			exp_rd   = exp_rd_q.pop_front();
			exp_data = exp_data_q.pop_front();
			check_value("wb_rd", 32'(wb_rd), 32'(exp_rd));
			check_value("wb_data", wb_data, exp_data);
		end
	end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stimulus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic drive_idle();
	@(posedge clk);
	#1;
	in_valid = 1'b0;
endtask

task automatic drive_instruction(input logic [3:0] op_code, input uint32_t v_base,
	input uint32_t v_offset, input uint32_t v_store, input uint32_t v_reg2,
	input uint32_t v_alu, input logic [4:0] v_rd, input uint32_t v_expected);
	@(posedge clk);
	#1;
	in_valid   = 1'b1;
	op         = oper_t'(op_code);
	base       = v_base;
	offset     = v_offset;
	store_val  = v_store;
	reg2       = v_reg2;
	alu_result = v_alu;
	rd         = v_rd;
	exp_rd_q.push_back(v_rd);
	exp_data_q.push_back(v_expected);
endtask

initial begin
	int          fd;
	int          fields;
	int unsigned idle_cycles;
	int          wait_cycles;
	string       line;
	logic [3:0]  f_op;
	uint32_t     f_base, f_offset, f_store, f_reg2, f_alu, f_expected;
	logic [4:0]  f_rd;

	void'($urandom(32'h68d32bd0));
	rst        = 1'b1;
	in_valid   = 1'b0;
	op         = OP_ALU;
	base       = '0;
	offset     = '0;
	store_val  = '0;
	alu_result = '0;
	reg2       = '0;
	rd         = '0;
	repeat (5) @(posedge clk);
	#1;
	rst = 1'b0;

	fd = $fopen("test/mem_stimulus.txt", "r");
	if (fd == 0) begin
		$display("could not open the stimulus file test/mem_stimulus.txt");
		run_error_count++;
	end else begin
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") continue; // blank or column notes
			fields = $sscanf(line, "%h %h %h %h %h %h %h %h", f_op, f_base, f_offset,
				f_store, f_reg2, f_alu, f_rd, f_expected);
			if (fields != 8) begin
				$display("a stimulus line could not be read: %s", line);
				run_error_count++;
			end else begin
				idle_cycles = ($urandom % 4 == 3) ? 1 + $urandom % 2 : 0;
				repeat (idle_cycles) drive_idle(); // bubbles between instructions
				drive_instruction(f_op, f_base, f_offset, f_store, f_reg2, f_alu, f_rd,
					f_expected);
			end
		end
		$fclose(fd);
		drive_idle();
		wait_cycles = 0;
		while (exp_data_q.size() != 0 && wait_cycles < 50) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (exp_data_q.size() != 0) begin
			$display("timeout: %0d write-back results did not arrive within 50 cycles",
				exp_data_q.size());
			run_error_count++;
		end
	end

	$display("%0d checks, %0d mismatches, %0d run errors", check_count, error_count,
		run_error_count);
	if (error_count == 0 && run_error_count == 0) begin
		$display("all tests passed");
	end else begin
		$display("tests failed");
	end
	$finish;
end

endmodule
